//--- hw/exec_units.sv
/*
 * Execution units
 * Combinational negation and the add pipe, which carries its
 * destination index and valid bit alongside the sum
 */

`timescale 1ns/1ps

module exec_units (
   input  logic                   clk,
   input  logic                   reset,

   // Neg unit
   input  vliw_types_pkg::word_t  neg_operand,
   output vliw_types_pkg::word_t  neg_result,

   // Add unit
   input  vliw_types_pkg::word_t  add_operand1,
   input  vliw_types_pkg::word_t  add_operand2,
   input  logic                   add_enable,
   input  vliw_types_pkg::addr_t  add_dest,

   output logic                   add_wb_valid,
   output vliw_types_pkg::index_t add_wb_index,
   output vliw_types_pkg::word_t  add_wb_value
);

   vliw_types_pkg::word_t add_sum;

   // Two's complement, wraps modulo the word width
   assign neg_result = -neg_operand;

   assign add_sum = add_operand1 + add_operand2;

   // ========================================================================
   // Add pipe stage
   // ========================================================================
   always_ff @(posedge clk) begin
      if (reset) begin
         add_wb_valid <= 1'b0;
      end else begin
         add_wb_valid <= add_enable;
      end
   end

   // Destination travels with its own sum
   always_ff @(posedge clk) begin
      add_wb_index <= add_dest[vliw_config_pkg::INDEX_WIDTH-1:0];
      add_wb_value <= add_sum;
   end

endmodule

//--- hw/operand_fetch.sv
/*
 * Operand fetch
 * Splits each read address into bank code and index and selects
 * the bank word, the z register or zero for the reserved bank
 */

`timescale 1ns/1ps

module operand_fetch #(
   parameter int READ_PORTS = 4
) (
   input  vliw_types_pkg::addr_t  read_addr  [READ_PORTS],
   output vliw_types_pkg::index_t read_index [READ_PORTS],

   input  vliw_types_pkg::word_t  bank_data  [vliw_config_pkg::NUM_UNIT_BANKS][READ_PORTS],
   input  vliw_types_pkg::word_t  z_value,

   output vliw_types_pkg::word_t  operand    [READ_PORTS]
);

   localparam int ADDR_MSB  = vliw_config_pkg::ADDR_WIDTH - 1;
   localparam int INDEX_MSB = vliw_config_pkg::INDEX_WIDTH - 1;

   for (genvar p = 0; p < READ_PORTS; p++) begin : g_port
      vliw_types_pkg::bank_e bank;
      vliw_types_pkg::word_t bank_word;

      assign bank          = vliw_types_pkg::bank_e'(read_addr[p][ADDR_MSB:INDEX_MSB+1]);
      assign read_index[p] = read_addr[p][INDEX_MSB:0];

      always_comb begin
         case (bank)
            vliw_types_pkg::BANK_LOAD: begin
               bank_word = bank_data[vliw_types_pkg::BANK_LOAD][p];
            end
            vliw_types_pkg::BANK_NEG: begin
               bank_word = bank_data[vliw_types_pkg::BANK_NEG][p];
            end
            vliw_types_pkg::BANK_ADD: begin
               bank_word = bank_data[vliw_types_pkg::BANK_ADD][p];
            end
            default: begin
               bank_word = '0;
            end
         endcase
      end

      // Reserved bank reads zero even at index 0, z only shows in real banks
      always_comb begin
         if (bank == vliw_types_pkg::BANK_RESERVED) begin
            operand[p] = '0;
         end else if (read_index[p] == '0) begin
            operand[p] = z_value;
         end else begin
            operand[p] = bank_word;
         end
      end
   end

endmodule

//--- hw/register_bank.sv
/*
 * Result bank of one execution unit
 * Single synchronous write port, NUM_READS combinational read ports
 */

`timescale 1ns/1ps

module register_bank #(
   parameter int NUM_READS = 4
) (
   input  logic                   clk,

   input  logic                   write_enable,
   input  vliw_types_pkg::index_t write_index,
   input  vliw_types_pkg::word_t  write_value,

   input  vliw_types_pkg::index_t read_index [NUM_READS],
   output vliw_types_pkg::word_t  read_data  [NUM_READS]
);

   localparam int DEPTH = 2 ** vliw_config_pkg::INDEX_WIDTH;

   vliw_types_pkg::word_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (write_enable) begin
         mem[write_index] <= write_value;
      end
   end

   // Reads see stored state only, no bypass from the write port
   for (genvar r = 0; r < NUM_READS; r++) begin : g_read
      assign read_data[r] = mem[read_index[r]];
   end

endmodule

//--- hw/register_files.sv
/*
 * Banked register storage of the VLIW core
 * One bank per unit plus the shared z register at index 0,
 * with load over neg over add when several units write z together
 */

`timescale 1ns/1ps

module register_files #(
   parameter int READ_PORTS = 4
) (
   input  logic                   clk,
   input  logic                   reset,

   // Load unit write
   input  logic                   load_enable,
   input  vliw_types_pkg::index_t load_index,
   input  vliw_types_pkg::word_t  load_value,

   // Neg unit write
   input  logic                   neg_enable,
   input  vliw_types_pkg::index_t neg_index,
   input  vliw_types_pkg::word_t  neg_value,

   // Add pipe write-back
   input  logic                   add_enable,
   input  vliw_types_pkg::index_t add_index,
   input  vliw_types_pkg::word_t  add_value,

   input  vliw_types_pkg::index_t read_index [READ_PORTS],
   output vliw_types_pkg::word_t  bank_data  [vliw_config_pkg::NUM_UNIT_BANKS][READ_PORTS],
   output vliw_types_pkg::word_t  z_value
);

   logic                   wr_enable [vliw_config_pkg::NUM_UNIT_BANKS];
   vliw_types_pkg::index_t wr_index  [vliw_config_pkg::NUM_UNIT_BANKS];
   vliw_types_pkg::word_t  wr_value  [vliw_config_pkg::NUM_UNIT_BANKS];

   // ========================================================================
   // Bank write requests
   // ========================================================================
   // Index 0 goes to z instead of the bank entry
   assign wr_enable[vliw_types_pkg::BANK_LOAD] = load_enable && (load_index != '0);
   assign wr_index[vliw_types_pkg::BANK_LOAD]  = load_index;
   assign wr_value[vliw_types_pkg::BANK_LOAD]  = load_value;

   assign wr_enable[vliw_types_pkg::BANK_NEG] = neg_enable && (neg_index != '0);
   assign wr_index[vliw_types_pkg::BANK_NEG]  = neg_index;
   assign wr_value[vliw_types_pkg::BANK_NEG]  = neg_value;

   assign wr_enable[vliw_types_pkg::BANK_ADD] = add_enable && (add_index != '0);
   assign wr_index[vliw_types_pkg::BANK_ADD]  = add_index;
   assign wr_value[vliw_types_pkg::BANK_ADD]  = add_value;

   for (genvar b = 0; b < vliw_config_pkg::NUM_UNIT_BANKS; b++) begin : g_bank
      register_bank #(
         .NUM_READS    (READ_PORTS)
      ) i_register_bank (
         .clk          (clk),
         .write_enable (wr_enable[b]),
         .write_index  (wr_index[b]),
         .write_value  (wr_value[b]),
         .read_index   (read_index),
         .read_data    (bank_data[b])
      );
   end

   // ========================================================================
   // Z register
   // ========================================================================
   always_ff @(posedge clk) begin
      if (reset) begin
         z_value <= '0;
      end else if (load_enable && load_index == '0) begin
         z_value <= load_value;
      end else if (neg_enable && neg_index == '0) begin
         z_value <= neg_value;
      end else if (add_enable && add_index == '0) begin
         z_value <= add_value;
      end
   end

endmodule

//--- hw/vliw_config_pkg.sv
/*
 * VLIW core configuration
 * Data and address widths, bank count and add pipe latency
 */

package vliw_config_pkg;

   // ========================================================================
   // Datapath widths
   // ========================================================================
   localparam int WORD_WIDTH  = 27;
   localparam int ADDR_WIDTH  = 10;
   localparam int INDEX_WIDTH = 8;

   // ========================================================================
   // Core organization
   // ========================================================================
   // Result banks owned by load, neg and add
   localparam int NUM_UNIT_BANKS = 3;

   // Cycles from add issue until the sum can be read
   localparam int ADD_LATENCY = 2;

endpackage

//--- hw/vliw_top.sv
/*
 * VLIW core top level
 * Three parallel slots (load, neg, add) over banked result storage,
 * plus a combinational read-back port
 */

`timescale 1ns/1ps

module vliw_top #(
   parameter int READ_PORTS = 4
) (
   input  logic                  clk,
   input  logic                  reset,

   input  logic                  load_enable,
   input  vliw_types_pkg::word_t load_value,
   input  vliw_types_pkg::addr_t load_dest,

   input  logic                  neg_enable,
   input  vliw_types_pkg::addr_t neg_src,
   input  vliw_types_pkg::addr_t neg_dest,

   input  logic                  add_enable,
   input  vliw_types_pkg::addr_t add_src1,
   input  vliw_types_pkg::addr_t add_src2,
   input  vliw_types_pkg::addr_t add_dest,

   input  vliw_types_pkg::addr_t dbg_addr,
   output vliw_types_pkg::word_t dbg_data
);

   // Read port assignment
   localparam int PORT_NEG  = 0;
   localparam int PORT_ADD1 = 1;
   localparam int PORT_ADD2 = 2;
   localparam int PORT_DBG  = 3;

   localparam int INDEX_MSB = vliw_config_pkg::INDEX_WIDTH - 1;

   vliw_types_pkg::addr_t  read_addr  [READ_PORTS];
   vliw_types_pkg::index_t read_index [READ_PORTS];
   vliw_types_pkg::word_t  bank_data  [vliw_config_pkg::NUM_UNIT_BANKS][READ_PORTS];
   vliw_types_pkg::word_t  operand    [READ_PORTS];
   vliw_types_pkg::word_t  z_value;

   vliw_types_pkg::word_t  neg_result;
   logic                   add_wb_valid;
   vliw_types_pkg::index_t add_wb_index;
   vliw_types_pkg::word_t  add_wb_value;

   // ========================================================================
   // Fetch
   // ========================================================================
   assign read_addr[PORT_NEG]  = neg_src;
   assign read_addr[PORT_ADD1] = add_src1;
   assign read_addr[PORT_ADD2] = add_src2;
   assign read_addr[PORT_DBG]  = dbg_addr;

   assign dbg_data = operand[PORT_DBG];

   operand_fetch #(
      .READ_PORTS (READ_PORTS)
   ) i_operand_fetch (
      .read_addr  (read_addr),
      .read_index (read_index),
      .bank_data  (bank_data),
      .z_value    (z_value),
      .operand    (operand)
   );

   // ========================================================================
   // Execute
   // ========================================================================
   exec_units i_exec_units (
      .clk          (clk),
      .reset        (reset),
      .neg_operand  (operand[PORT_NEG]),
      .neg_result   (neg_result),
      .add_operand1 (operand[PORT_ADD1]),
      .add_operand2 (operand[PORT_ADD2]),
      .add_enable   (add_enable),
      .add_dest     (add_dest),
      .add_wb_valid (add_wb_valid),
      .add_wb_index (add_wb_index),
      .add_wb_value (add_wb_value)
   );

   // ========================================================================
   // Write-back
   // ========================================================================
   register_files #(
      .READ_PORTS  (READ_PORTS)
   ) i_register_files (
      .clk         (clk),
      .reset       (reset),
      .load_enable (load_enable),
      .load_index  (load_dest[INDEX_MSB:0]),
      .load_value  (load_value),
      .neg_enable  (neg_enable),
      .neg_index   (neg_dest[INDEX_MSB:0]),
      .neg_value   (neg_result),
      .add_enable  (add_wb_valid),
      .add_index   (add_wb_index),
      .add_value   (add_wb_value),
      .read_index  (read_index),
      .bank_data   (bank_data),
      .z_value     (z_value)
   );

endmodule

//--- hw/vliw_types_pkg.sv
/*
 * VLIW core types
 * Data word, operand address, entry index and bank code
 */

package vliw_types_pkg;

   typedef logic [vliw_config_pkg::WORD_WIDTH-1:0]  word_t;
   typedef logic [vliw_config_pkg::ADDR_WIDTH-1:0]  addr_t;
   typedef logic [vliw_config_pkg::INDEX_WIDTH-1:0] index_t;

   // ========================================================================
   // Bank code, upper bits of an operand address
   // ========================================================================
   // Values double as the bank number inside the register files
   typedef enum logic [vliw_config_pkg::ADDR_WIDTH-vliw_config_pkg::INDEX_WIDTH-1:0] {
      BANK_LOAD     = 2'd0,
      BANK_NEG      = 2'd1,
      BANK_ADD      = 2'd2,
      BANK_RESERVED = 2'd3
   } bank_e;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build the VLIW core testbench with Verilator and run it

verilator --binary --timing --assert -f verilog.f --top-module vliw_tb -o vliw_sim &&
./obj_dir/vliw_sim 2>&1 | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- test/vliw_properties.sv
/*
 * Bound assertions on the VLIW core
 * Add pipe valid tracking and reserved bank read-back
 */

`timescale 1ns/1ps

module vliw_properties (
   input logic                  clk,
   input logic                  reset,
   input logic                  add_enable,
   input logic                  add_wb_valid,
   input vliw_types_pkg::addr_t dbg_addr,
   input vliw_types_pkg::word_t dbg_data
);

   localparam int ADDR_MSB    = vliw_config_pkg::ADDR_WIDTH - 1;
   localparam int INDEX_WIDTH = vliw_config_pkg::INDEX_WIDTH;

   vliw_types_pkg::bank_e dbg_bank;

   assign dbg_bank = vliw_types_pkg::bank_e'(dbg_addr[ADDR_MSB:INDEX_WIDTH]);

   no_wb_after_reset: assert property (@(posedge clk) reset |=> !add_wb_valid)
      else $error("Add write-back in the cycle after reset");

   // One register stage between issue and write-back
   wb_follows_issue: assert property (@(posedge clk)
      !reset |=> (add_wb_valid == $past(add_enable)))
      else $error("Add write-back valid does not follow add enable");

   reserved_reads_zero: assert property (@(posedge clk)
      (dbg_bank == vliw_types_pkg::BANK_RESERVED) |-> (dbg_data == '0))
      else $error("Reserved bank read returned a nonzero word");

endmodule

bind vliw_top vliw_properties i_vliw_properties (
   .clk          (clk),
   .reset        (reset),
   .add_enable   (add_enable),
   .add_wb_valid (add_wb_valid),
   .dbg_addr     (dbg_addr),
   .dbg_data     (dbg_data)
);

//--- test/vliw_tb.sv
/*
 * Testbench of the VLIW core
 * Directed tests of load, neg, add, the z register and the reserved bank,
 * checked through the read-back port
 */

`timescale 1ns/1ps

module vliw_tb;

   localparam int SEED        = 59218;
   localparam int INDEX_WIDTH = vliw_config_pkg::INDEX_WIDTH;
   localparam int ADDR_MSB    = vliw_config_pkg::ADDR_WIDTH - 1;
   localparam int DEPTH       = 2 ** INDEX_WIDTH;
   localparam int NUM_ADDS    = 4;

   logic                  clk;
   logic                  reset;
   logic                  load_enable;
   vliw_types_pkg::word_t load_value;
   vliw_types_pkg::addr_t load_dest;
   logic                  neg_enable;
   vliw_types_pkg::addr_t neg_src;
   vliw_types_pkg::addr_t neg_dest;
   logic                  add_enable;
   vliw_types_pkg::addr_t add_src1;
   vliw_types_pkg::addr_t add_src2;
   vliw_types_pkg::addr_t add_dest;
   vliw_types_pkg::addr_t dbg_addr;
   vliw_types_pkg::word_t dbg_data;

   // Expected contents of banks and z
   vliw_types_pkg::word_t exp_load [DEPTH];
   vliw_types_pkg::word_t exp_neg  [DEPTH];
   vliw_types_pkg::word_t exp_add  [DEPTH];
   vliw_types_pkg::word_t exp_z;

   vliw_top #(
      .READ_PORTS  (4)
   ) i_vliw_top (
      .clk         (clk),
      .reset       (reset),
      .load_enable (load_enable),
      .load_value  (load_value),
      .load_dest   (load_dest),
      .neg_enable  (neg_enable),
      .neg_src     (neg_src),
      .neg_dest    (neg_dest),
      .add_enable  (add_enable),
      .add_src1    (add_src1),
      .add_src2    (add_src2),
      .add_dest    (add_dest),
      .dbg_addr    (dbg_addr),
      .dbg_data    (dbg_data)
   );

   always #2 clk = ~clk;

   // ========================================================================
   // Expected-value model
   // ========================================================================
   function automatic vliw_types_pkg::addr_t make_addr(vliw_types_pkg::bank_e bank,
                                                       vliw_types_pkg::index_t index);
      return {bank, index};
   endfunction

   function automatic vliw_types_pkg::word_t twos_negate(vliw_types_pkg::word_t value);
      return (~value) + vliw_types_pkg::word_t'(1);
   endfunction

   function automatic vliw_types_pkg::word_t expected_read(vliw_types_pkg::addr_t addr);
      vliw_types_pkg::bank_e  bank;
      vliw_types_pkg::index_t index;
      bank  = vliw_types_pkg::bank_e'(addr[ADDR_MSB:INDEX_WIDTH]);
      index = addr[INDEX_WIDTH-1:0];
      if (bank == vliw_types_pkg::BANK_RESERVED) begin
         return '0;
      end else if (index == '0) begin
         return exp_z;
      end else if (bank == vliw_types_pkg::BANK_LOAD) begin
         return exp_load[index];
      end else if (bank == vliw_types_pkg::BANK_NEG) begin
         return exp_neg[index];
      end
      return exp_add[index];
   endfunction

   function automatic void record_write(vliw_types_pkg::bank_e bank,
                                        vliw_types_pkg::index_t index,
                                        vliw_types_pkg::word_t value);
      if (index == '0) begin
         exp_z = value;
      end else if (bank == vliw_types_pkg::BANK_LOAD) begin
         exp_load[index] = value;
      end else if (bank == vliw_types_pkg::BANK_NEG) begin
         exp_neg[index] = value;
      end else begin
         exp_add[index] = value;
      end
   endfunction

   // ========================================================================
   // Drive and check helpers
   // ========================================================================
   task automatic check_word(string test, vliw_types_pkg::word_t expected,
                             vliw_types_pkg::word_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected 0x%h, actual 0x%h", test, expected, actual);
         $display("SOME TESTS FAILED");
         $fatal(1, "Read-back mismatch");
      end
   endtask

   // Slots idle unless the caller enables them after this
   task automatic start_cycle();
      @(posedge clk);
      load_enable <= 1'b0;
      neg_enable  <= 1'b0;
      add_enable  <= 1'b0;
   endtask

   task automatic sample_dbg(string test, vliw_types_pkg::addr_t addr);
      dbg_addr <= addr;
      @(negedge clk);
      check_word(test, expected_read(addr), dbg_data);
   endtask

   task automatic issue_load(vliw_types_pkg::addr_t dest, vliw_types_pkg::word_t value);
      load_enable <= 1'b1;
      load_dest   <= dest;
      load_value  <= value;
      record_write(vliw_types_pkg::BANK_LOAD, dest[INDEX_WIDTH-1:0], value);
   endtask

   task automatic issue_neg(vliw_types_pkg::addr_t src, vliw_types_pkg::addr_t dest);
      neg_enable <= 1'b1;
      neg_src    <= src;
      neg_dest   <= dest;
      record_write(vliw_types_pkg::BANK_NEG, dest[INDEX_WIDTH-1:0],
                   twos_negate(expected_read(src)));
   endtask

   // ========================================================================
   // Directed tests
   // ========================================================================
   task automatic test_z_after_reset();
      for (int b = 0; b < 4; b++) begin
         start_cycle();
         sample_dbg("z_after_reset", make_addr(vliw_types_pkg::bank_e'(b), '0));
      end
   endtask

   task automatic test_loads();
      vliw_types_pkg::index_t index;
      for (int i = 0; i < 8; i++) begin
         index = vliw_types_pkg::index_t'(i * 29 + 1);
         start_cycle();
         issue_load(make_addr(vliw_types_pkg::BANK_LOAD, index),
                    vliw_types_pkg::word_t'($urandom));
         start_cycle();
         sample_dbg("loads", make_addr(vliw_types_pkg::BANK_LOAD, index));
      end
      // Bank bits of a destination are ignored
      start_cycle();
      issue_load(make_addr(vliw_types_pkg::BANK_ADD, 8'd200), vliw_types_pkg::word_t'($urandom));
      start_cycle();
      sample_dbg("loads", make_addr(vliw_types_pkg::BANK_LOAD, 8'd200));
   endtask

   task automatic test_negation();
      vliw_types_pkg::word_t values [3];
      values[0] = vliw_types_pkg::word_t'($urandom);
      values[1] = vliw_types_pkg::word_t'(1);
      values[2] = vliw_types_pkg::word_t'(27'h4000000);
      foreach (values[i]) begin
         start_cycle();
         issue_load(make_addr(vliw_types_pkg::BANK_LOAD, 8'd50), values[i]);
         start_cycle();
         issue_neg(make_addr(vliw_types_pkg::BANK_LOAD, 8'd50),
                   make_addr(vliw_types_pkg::BANK_NEG, 8'd60));
         start_cycle();
         issue_neg(make_addr(vliw_types_pkg::BANK_NEG, 8'd60),
                   make_addr(vliw_types_pkg::BANK_NEG, 8'd61));
         sample_dbg("negation", make_addr(vliw_types_pkg::BANK_NEG, 8'd60));
         start_cycle();
         sample_dbg("negation", make_addr(vliw_types_pkg::BANK_NEG, 8'd61));
      end
   endtask

   task automatic test_adds();
      vliw_types_pkg::addr_t  src1 [NUM_ADDS];
      vliw_types_pkg::addr_t  src2 [NUM_ADDS];
      vliw_types_pkg::index_t dest [NUM_ADDS];
      vliw_types_pkg::word_t  sum  [NUM_ADDS];
      start_cycle();
      issue_load(make_addr(vliw_types_pkg::BANK_LOAD, 8'd10), vliw_types_pkg::word_t'($urandom));
      start_cycle();
      issue_load(make_addr(vliw_types_pkg::BANK_LOAD, 8'd11), vliw_types_pkg::word_t'($urandom));
      // Later adds consume sums of earlier ones
      src1[0] = make_addr(vliw_types_pkg::BANK_LOAD, 8'd10);
      src2[0] = make_addr(vliw_types_pkg::BANK_LOAD, 8'd11);
      src1[1] = make_addr(vliw_types_pkg::BANK_LOAD, 8'd11);
      src2[1] = make_addr(vliw_types_pkg::BANK_LOAD, 8'd11);
      src1[2] = make_addr(vliw_types_pkg::BANK_ADD, 8'd20);
      src2[2] = make_addr(vliw_types_pkg::BANK_LOAD, 8'd10);
      src1[3] = make_addr(vliw_types_pkg::BANK_ADD, 8'd21);
      src2[3] = make_addr(vliw_types_pkg::BANK_ADD, 8'd20);
      for (int i = 0; i < NUM_ADDS; i++) begin
         dest[i] = vliw_types_pkg::index_t'(20 + i);
      end
      for (int c = 0; c < NUM_ADDS + vliw_config_pkg::ADD_LATENCY; c++) begin
         start_cycle();
         if (c >= vliw_config_pkg::ADD_LATENCY) begin
            record_write(vliw_types_pkg::BANK_ADD, dest[c - vliw_config_pkg::ADD_LATENCY],
                         sum[c - vliw_config_pkg::ADD_LATENCY]);
         end
         if (c < NUM_ADDS) begin
            sum[c]     = expected_read(src1[c]) + expected_read(src2[c]);
            add_enable <= 1'b1;
            add_src1   <= src1[c];
            add_src2   <= src2[c];
            add_dest   <= make_addr(vliw_types_pkg::BANK_ADD, dest[c]);
         end
         if (c >= vliw_config_pkg::ADD_LATENCY) begin
            sample_dbg("adds", make_addr(vliw_types_pkg::BANK_ADD,
                                         dest[c - vliw_config_pkg::ADD_LATENCY]));
         end
      end
   endtask

   task automatic test_z_register();
      vliw_types_pkg::word_t sum;
      start_cycle();
      issue_load(make_addr(vliw_types_pkg::BANK_LOAD, '0), vliw_types_pkg::word_t'($urandom));
      for (int b = 0; b < 4; b++) begin
         start_cycle();
         sample_dbg("z_load", make_addr(vliw_types_pkg::bank_e'(b), '0));
      end
      // Load issued after neg so the model also keeps the load value
      start_cycle();
      issue_neg(make_addr(vliw_types_pkg::BANK_LOAD, 8'd10),
                make_addr(vliw_types_pkg::BANK_NEG, '0));
      issue_load(make_addr(vliw_types_pkg::BANK_LOAD, '0), vliw_types_pkg::word_t'($urandom));
      start_cycle();
      sample_dbg("z_load_over_neg", make_addr(vliw_types_pkg::BANK_LOAD, '0));
      // Add write-back and neg land on the same edge
      start_cycle();
      sum        = expected_read(make_addr(vliw_types_pkg::BANK_LOAD, 8'd10))
                   + expected_read(make_addr(vliw_types_pkg::BANK_LOAD, 8'd11));
      add_enable <= 1'b1;
      add_src1   <= make_addr(vliw_types_pkg::BANK_LOAD, 8'd10);
      add_src2   <= make_addr(vliw_types_pkg::BANK_LOAD, 8'd11);
      add_dest   <= make_addr(vliw_types_pkg::BANK_ADD, '0);
      start_cycle();
      record_write(vliw_types_pkg::BANK_ADD, '0, sum);
      issue_neg(make_addr(vliw_types_pkg::BANK_LOAD, 8'd11),
                make_addr(vliw_types_pkg::BANK_NEG, '0));
      start_cycle();
      sample_dbg("z_neg_over_add", make_addr(vliw_types_pkg::BANK_ADD, '0));
   endtask

   task automatic test_reserved_bank();
      start_cycle();
      issue_load(make_addr(vliw_types_pkg::BANK_LOAD, 8'd7), vliw_types_pkg::word_t'(27'h1234567));
      start_cycle();
      issue_neg(make_addr(vliw_types_pkg::BANK_RESERVED, 8'd7),
                make_addr(vliw_types_pkg::BANK_NEG, 8'd70));
      sample_dbg("reserved", make_addr(vliw_types_pkg::BANK_RESERVED, 8'd7));
      start_cycle();
      sample_dbg("reserved", make_addr(vliw_types_pkg::BANK_NEG, 8'd70));
      start_cycle();
      sample_dbg("reserved", make_addr(vliw_types_pkg::BANK_RESERVED, '0));
      start_cycle();
      sample_dbg("reserved", make_addr(vliw_types_pkg::BANK_RESERVED, 8'd60));
   endtask

   // ========================================================================
   // Main sequence
   // ========================================================================
   initial begin
      void'($urandom(SEED));
      clk         = 1'b0;
      reset       = 1'b1;
      // Load to z and add stay enabled through reset without any effect
      load_enable = 1'b1;
      load_value  = vliw_types_pkg::word_t'(27'h2a5a5a5);
      load_dest   = '0;
      neg_enable  = 1'b0;
      neg_src     = '0;
      neg_dest    = '0;
      add_enable  = 1'b1;
      add_src1    = '0;
      add_src2    = '0;
      add_dest    = '0;
      dbg_addr    = '0;
      exp_z       = '0;
      repeat (8) @(posedge clk);
      reset       <= 1'b0;
      load_enable <= 1'b0;
      add_enable  <= 1'b0;

      test_z_after_reset();
      test_loads();
      test_negation();
      test_adds();
      test_z_register();
      test_reserved_bank();

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- verilog.f
hw/vliw_config_pkg.sv
hw/vliw_types_pkg.sv
hw/register_bank.sv
hw/register_files.sv
hw/operand_fetch.sv
hw/exec_units.sv
hw/vliw_top.sv
test/vliw_properties.sv
test/vliw_tb.sv
